//--- verilog/uart_dbg_cfg.svh
// Build-time settings of the UART debug endpoint
// CLKS_PER_BIT must be a power of two of at least 4
// FIELD_BYTES of 8 gives the 64-bit exec entry address

`ifndef UART_DBG_CFG_SVH
`define UART_DBG_CFG_SVH

// Clock cycles per serial bit
`define UART_DBG_CLKS_PER_BIT 16

// 1 adds an even parity bit after the data bits
`define UART_DBG_PARITY_EN 1

// Byte memory address bits, 256 bytes
`define UART_DBG_MEM_AW 8

// Low length bytes that count
`define UART_DBG_LEN_BYTES 2

// Bytes in an address or length field
`define UART_DBG_FIELD_BYTES 8

`endif

//--- verilog/uart_line_pkg.sv
// Types of the serial byte layer
// Each received byte is passed on, with a parity error flagged

`default_nettype none

package uart_line_pkg;

  // Received byte, valid for one cycle
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       parity_err;
  } line_byte_t;

  // Byte to send, taken by the transmitter while it is not busy
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } tx_req_t;

  typedef enum logic [2:0] {
    LINE_IDLE, LINE_START, LINE_DATA, LINE_PARITY, LINE_STOP
  } line_state_e;

endpackage

`default_nettype wire

//--- verilog/uart_dbg_pkg.sv
// Types of the debug-boot protocol
// Multi-byte fields go over the line least significant byte first

`default_nettype none

package uart_dbg_pkg;

  // Protocol bytes
  typedef enum logic [7:0] {
    EOT       = 8'h04,
    ACK       = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13,
    EOC       = 8'h14
  } dbg_op_e;

  typedef enum logic [3:0] {
    ST_IDLE, ST_GET_ADDR, ST_GET_LEN, ST_SEND_ACK, ST_STREAM_RD,
    ST_STREAM_WR, ST_SEND_EOT, ST_SEND_EOC, ST_SEND_CODE
  } dbg_state_e;

  // Start of execution at an entry address
  typedef struct packed {
    logic        valid;
    logic [63:0] entry;
  } dbg_exec_t;

  // End of computation with exit code
  typedef struct packed {
    logic        valid;
    logic [31:0] code;
  } dbg_eoc_t;

endpackage

`default_nettype wire

//--- verilog/uart_byte_rx.sv
// UART receiver, 8 data bits, optional even parity, one stop bit
// Stop bit level is not checked; a high start bit middle is a glitch

`default_nettype none
`include "uart_dbg_cfg.svh"

module uart_byte_rx import uart_line_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       rx_i,
  output line_byte_t byte_o
);

  localparam int TW = $clog2(`UART_DBG_CLKS_PER_BIT);
  localparam logic [TW-1:0] T_HALF = TW'(`UART_DBG_CLKS_PER_BIT / 2 - 1);
  localparam logic [TW-1:0] T_FULL = TW'(`UART_DBG_CLKS_PER_BIT - 1);

  line_state_e   state_q;
  logic [2:0]    sync_q;
  logic [TW-1:0] timer_q;
  logic [2:0]    bit_q;
  logic [7:0]    shift_q;
  logic          perr_q;
  logic          valid_q;
  logic          rx_s;
  logic          fall;
  logic          tick;

  // Two sync flops, the third keeps the previous level for edge detection
  assign rx_s = sync_q[1];
  assign fall = sync_q[2] & ~sync_q[1];
  // Start bit is sampled at half a period, the rest at full periods
  assign tick = (state_q == LINE_START) ? (timer_q == T_HALF) : (timer_q == T_FULL);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= 3'b111;
      state_q <= LINE_IDLE;
      timer_q <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[1:0], rx_i};
      valid_q <= 1'b0;
      if (state_q == LINE_IDLE) begin
        timer_q <= '0;
        bit_q   <= '0;
        if (fall) begin
          state_q <= LINE_START;
        end
      end else if (!tick) begin
        timer_q <= timer_q + 1'b1;
      end else begin
        timer_q <= '0;
        case (state_q)
          LINE_START: state_q <= rx_s ? LINE_IDLE : LINE_DATA;
          LINE_DATA: begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= (`UART_DBG_PARITY_EN != 0) ? LINE_PARITY : LINE_STOP;
            end
          end
          LINE_PARITY: state_q <= LINE_STOP;
          LINE_STOP: begin
            valid_q <= 1'b1;
            state_q <= LINE_IDLE;
          end
          default: state_q <= LINE_IDLE;
        endcase
      end
    end
  end

  // Data and parity check, LSB first
  always_ff @(posedge clk) begin
    if (tick && state_q == LINE_START) begin
      perr_q <= 1'b0;
    end
    if (tick && state_q == LINE_DATA) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if (tick && state_q == LINE_PARITY) begin
      perr_q <= rx_s ^ (^shift_q);
    end
  end

  assign byte_o = '{valid: valid_q, data: shift_q, parity_err: perr_q};

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    byte_o.valid |=> !byte_o.valid);

endmodule

`default_nettype wire

//--- verilog/uart_byte_tx.sv
// UART transmitter, one byte per request, line idles high
// A request is only taken while busy_o is low

`default_nettype none
`include "uart_dbg_cfg.svh"

module uart_byte_tx import uart_line_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  tx_req_t req_i,
  output logic    busy_o,
  output logic    tx_o
);

  localparam int TW = $clog2(`UART_DBG_CLKS_PER_BIT);
  localparam logic [TW-1:0] T_FULL = TW'(`UART_DBG_CLKS_PER_BIT - 1);

  line_state_e   state_q;
  logic [TW-1:0] timer_q;
  logic [2:0]    bit_q;
  logic [7:0]    shift_q;
  logic          par_q;
  logic          tx_q;
  logic          tick;

  assign tick   = (timer_q == T_FULL);
  assign busy_o = (state_q != LINE_IDLE);
  assign tx_o   = tx_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LINE_IDLE;
      timer_q <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else if (state_q == LINE_IDLE) begin
      timer_q <= '0;
      bit_q   <= '0;
      if (req_i.valid) begin
        state_q <= LINE_START;
        tx_q    <= 1'b0;
      end
    end else if (!tick) begin
      timer_q <= timer_q + 1'b1;
    end else begin
      timer_q <= '0;
      case (state_q)
        LINE_START: begin
          state_q <= LINE_DATA;
          tx_q    <= shift_q[0];
        end
        LINE_DATA: begin
          bit_q <= bit_q + 1'b1;
          if (bit_q != 3'd7) begin
            tx_q <= shift_q[0];
          end else if (`UART_DBG_PARITY_EN != 0) begin
            state_q <= LINE_PARITY;
            tx_q    <= par_q;
          end else begin
            state_q <= LINE_STOP;
            tx_q    <= 1'b1;
          end
        end
        LINE_PARITY: begin
          state_q <= LINE_STOP;
          tx_q    <= 1'b1;
        end
        default: state_q <= LINE_IDLE;
      endcase
    end
  end

  // Shift register moves one bit on every start or data bit boundary
  always_ff @(posedge clk) begin
    if (state_q == LINE_IDLE && req_i.valid) begin
      shift_q <= req_i.data;
      par_q   <= ^req_i.data;
    end else if (tick && (state_q == LINE_START || state_q == LINE_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q == LINE_IDLE) |-> tx_o);
  a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_i.valid |-> !busy_o);

endmodule

`default_nettype wire

//--- verilog/uart_dbg_engine.sv
// Debug-boot command engine with a small byte memory
// Addresses wrap at the memory depth, only the low length bytes count
// Bytes that arrive while a response is sent are not taken

`default_nettype none
`include "uart_dbg_cfg.svh"

module uart_dbg_engine import uart_line_pkg::*, uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  line_byte_t rx_byte_i,
  output tx_req_t    tx_req_o,
  input  logic       tx_busy_i,
  output dbg_exec_t  exec_o,
  input  dbg_eoc_t   eoc_i,
  output logic       parity_err_o
);

  localparam int FW    = 8 * `UART_DBG_FIELD_BYTES;
  localparam int LW    = 8 * `UART_DBG_LEN_BYTES;
  localparam int AW    = `UART_DBG_MEM_AW;
  localparam int CNT_W = $clog2(`UART_DBG_FIELD_BYTES);

  dbg_state_e       state_q;
  dbg_op_e          op_q;
  logic [CNT_W-1:0] cnt_q;
  logic [FW-1:0]    field_q;
  logic [FW-1:0]    field_next;
  logic [AW-1:0]    addr_q;
  logic [LW-1:0]    len_q;
  logic             eoc_pend_q;
  logic [31:0]      eoc_code_q;
  logic             parity_err_q;
  logic             byte_ok;
  logic             field_last;
  logic             tx_send;
  logic             tx_fire;
  logic [7:0]       tx_data;
  logic [7:0]       mem_q [2**AW];

  assign byte_ok    = rx_byte_i.valid && !rx_byte_i.parity_err;
  // Fields arrive LSB first and shift in from the top
  assign field_next = {rx_byte_i.data, field_q[FW-1:8]};
  assign field_last = (cnt_q == CNT_W'(`UART_DBG_FIELD_BYTES - 1));

  //////////////////////////////
  // Response byte
  //////////////////////////////

  always_comb begin
    tx_send = 1'b1;
    tx_data = EOT;
    case (state_q)
      ST_SEND_ACK:  tx_data = ACK;
      ST_STREAM_RD: tx_data = mem_q[addr_q];
      ST_SEND_EOT:  tx_data = EOT;
      ST_SEND_EOC:  tx_data = EOC;
      ST_SEND_CODE: tx_data = field_q[7:0];
      default:      tx_send = 1'b0;
    endcase
  end

  assign tx_fire      = tx_send && !tx_busy_i;
  assign tx_req_o     = '{valid: tx_fire, data: tx_data};
  // Exec fires together with its ACK
  assign exec_o       = '{valid: tx_fire && state_q == ST_SEND_ACK && op_q == CMD_EXEC,
                          entry: field_q};
  assign parity_err_o = parity_err_q;

  //////////////////////////////
  // Command FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      op_q         <= ACK;
      cnt_q        <= '0;
      addr_q       <= '0;
      len_q        <= '0;
      eoc_pend_q   <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      parity_err_q <= rx_byte_i.valid && rx_byte_i.parity_err;
      // A new EOC pulse wins over the clear of the old one
      if (eoc_i.valid) begin
        eoc_pend_q <= 1'b1;
      end else if (state_q == ST_SEND_EOC && tx_fire) begin
        eoc_pend_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (byte_ok) begin
            case (rx_byte_i.data)
              ACK: begin
                op_q    <= ACK;
                state_q <= ST_SEND_ACK;
              end
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                op_q    <= dbg_op_e'(rx_byte_i.data);
                cnt_q   <= '0;
                state_q <= ST_GET_ADDR;
              end
              default: ;
            endcase
          end else if (eoc_pend_q) begin
            state_q <= ST_SEND_EOC;
          end
        end
        ST_GET_ADDR: begin
          if (byte_ok) begin
            cnt_q <= cnt_q + 1'b1;
            if (field_last) begin
              addr_q  <= field_next[AW-1:0];
              cnt_q   <= '0;
              state_q <= (op_q == CMD_EXEC) ? ST_SEND_ACK : ST_GET_LEN;
            end
          end
        end
        ST_GET_LEN: begin
          if (byte_ok) begin
            cnt_q <= cnt_q + 1'b1;
            if (field_last) begin
              len_q   <= field_next[LW-1:0];
              state_q <= ST_SEND_ACK;
            end
          end
        end
        ST_SEND_ACK: begin
          if (tx_fire) begin
            if (op_q == CMD_READ || op_q == CMD_WRITE) begin
              if (len_q == '0) begin
                state_q <= ST_SEND_EOT;
              end else begin
                state_q <= (op_q == CMD_READ) ? ST_STREAM_RD : ST_STREAM_WR;
              end
            end else begin
              state_q <= ST_IDLE;
            end
          end
        end
        ST_STREAM_RD, ST_STREAM_WR: begin
          // Reads advance on each sent byte, writes on each received byte
          if ((state_q == ST_STREAM_RD) ? tx_fire : byte_ok) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
            if (len_q == LW'(1)) begin
              state_q <= ST_SEND_EOT;
            end
          end
        end
        ST_SEND_EOT: begin
          if (tx_fire) begin
            state_q <= ST_IDLE;
          end
        end
        ST_SEND_EOC: begin
          if (tx_fire) begin
            cnt_q   <= '0;
            state_q <= ST_SEND_CODE;
          end
        end
        ST_SEND_CODE: begin
          if (tx_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(3)) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Field shifter, also holds the exit code while it is sent
  always_ff @(posedge clk) begin
    if ((state_q == ST_GET_ADDR || state_q == ST_GET_LEN) && byte_ok) begin
      field_q <= field_next;
    end else if (state_q == ST_SEND_EOC && tx_fire) begin
      field_q <= FW'(eoc_code_q);
    end else if (state_q == ST_SEND_CODE && tx_fire) begin
      field_q <= field_q >> 8;
    end
  end

  always_ff @(posedge clk) begin
    if (eoc_i.valid) begin
      eoc_code_q <= eoc_i.code;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_STREAM_WR && byte_ok) begin
      mem_q[addr_q] <= rx_byte_i.data;
    end
  end

  // Each request is taken by the transmitter on the next cycle
  a_tx_handshake: assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_req_o.valid |-> !tx_busy_i ##1 tx_busy_i);

endmodule

`default_nettype wire

//--- verilog/uart_dbg_top.sv
// UART debug-boot endpoint
// exec_o pulses with the entry address, eoc_i reports an exit code

`default_nettype none

module uart_dbg_top import uart_line_pkg::*, uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  output dbg_exec_t exec_o,
  input  dbg_eoc_t  eoc_i,
  output logic      parity_err_o
);

  line_byte_t rx_byte;
  tx_req_t    tx_req;
  logic       tx_busy;

  uart_byte_rx u_rx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .rx_i    ( uart_rx_i ),
    .byte_o  ( rx_byte   )
  );

  uart_dbg_engine u_engine (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_byte_i    ( rx_byte      ),
    .tx_req_o     ( tx_req       ),
    .tx_busy_i    ( tx_busy      ),
    .exec_o       ( exec_o       ),
    .eoc_i        ( eoc_i        ),
    .parity_err_o ( parity_err_o )
  );

  uart_byte_tx u_tx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .req_i   ( tx_req    ),
    .busy_o  ( tx_busy   ),
    .tx_o    ( uart_tx_o )
  );

endmodule

`default_nettype wire

//--- bench/tb_uart_dbg.sv
// Self-checking bench for the UART debug endpoint, needs Verilator --timing
// Reads only memory bytes that an earlier write has set

`default_nettype none
`include "uart_dbg_cfg.svh"

module tb_uart_dbg import uart_line_pkg::*, uart_dbg_pkg::*; ();

  localparam int   CPB         = `UART_DBG_CLKS_PER_BIT;
  localparam logic PARITY_EN   = (`UART_DBG_PARITY_EN != 0);
  localparam int   FRAME_BITS  = PARITY_EN ? 11 : 10;
  localparam int   AW          = `UART_DBG_MEM_AW;
  localparam int   MEM_DEPTH   = 1 << AW;
  localparam int   LW          = 8 * `UART_DBG_LEN_BYTES;
  localparam int   FIELD_BYTES = `UART_DBG_FIELD_BYTES;
  // Worst-case frames per test, rx and tx, plus idle gaps
  localparam int   TEST_FRAMES = 2 + 118 + 91 + 10 + 56 + 6 + 24;
  localparam int   TIMEOUT_CYCLES = TEST_FRAMES * FRAME_BITS * CPB * 3 / 2;

  logic       clk;
  logic       rst_n;
  logic       uart_rx;
  logic       uart_tx;
  dbg_exec_t  exec_out;
  dbg_eoc_t   eoc_in;
  logic       parity_err;

  logic [31:0] lfsr_q = 32'h45f04e9c;
  logic [7:0]  ref_mem [MEM_DEPTH];
  logic [7:0]  wr_buf [$];
  logic [7:0]  exp_q [$];
  logic [7:0]  got_q [$];
  int          errors = 0;
  int          checked = 0;
  int          exec_cnt = 0;
  int          perr_cnt = 0;
  logic [63:0] exec_entry = '0;
  int          cycles = 0;

  uart_dbg_top dut0 (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n      ),
    .uart_rx_i    ( uart_rx    ),
    .uart_tx_o    ( uart_tx    ),
    .exec_o       ( exec_out   ),
    .eoc_i        ( eoc_in     ),
    .parity_err_o ( parity_err )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[62:0], fb};
    end
    return r;
  endfunction

  // Reference model, appends the expected response bytes
  function automatic void predict(input dbg_op_e op, input logic [63:0] addr,
                                  input int len, input logic [31:0] code);
    int i;
    int idx;
    case (op)
      CMD_WRITE, CMD_READ: begin
        exp_q.push_back(ACK);
        for (i = 0; i < len; i++) begin
          idx = (int'(addr[AW-1:0]) + i) % MEM_DEPTH;
          if (op == CMD_WRITE) begin
            ref_mem[idx] = wr_buf[i];
          end else begin
            exp_q.push_back(ref_mem[idx]);
          end
        end
        exp_q.push_back(EOT);
      end
      EOC: begin
        exp_q.push_back(EOC);
        for (i = 0; i < 4; i++) begin
          exp_q.push_back(code[8*i +: 8]);
        end
      end
      // ACK challenge and exec both get one ACK
      default: exp_q.push_back(ACK);
    endcase
  endfunction

  task automatic send_frame(input logic [7:0] data, input logic bad_par);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, PARITY_EN ? ((^data) ^ bad_par) : 1'b1, data, 1'b0};
    @(negedge clk);
    for (i = 0; i < FRAME_BITS; i++) begin
      uart_rx = bits[i];
      repeat (CPB) @(negedge clk);
    end
  endtask

  task automatic send_cmd(input dbg_op_e op, input logic [63:0] addr,
                          input logic [63:0] len_field);
    int i;
    send_frame(op, 1'b0);
    for (i = 0; i < FIELD_BYTES; i++) begin
      send_frame(addr[8*i +: 8], 1'b0);
    end
    if (op != CMD_EXEC) begin
      for (i = 0; i < FIELD_BYTES; i++) begin
        send_frame(len_field[8*i +: 8], 1'b0);
      end
    end
  endtask

  // Upper length bytes are random and must be ignored
  task automatic write_mem(input logic [63:0] addr, input int len);
    logic [63:0] lf;
    int          i;
    wr_buf.delete();
    for (i = 0; i < len; i++) begin
      wr_buf.push_back(8'(rand_bits(8)));
    end
    lf         = rand_bits(64);
    lf[LW-1:0] = LW'(len);
    predict(CMD_WRITE, addr, len, 32'h0);
    send_cmd(CMD_WRITE, addr, lf);
    for (i = 0; i < len; i++) begin
      send_frame(wr_buf[i], 1'b0);
    end
  endtask

  task automatic read_mem(input logic [63:0] addr, input int len);
    logic [63:0] lf;
    lf         = rand_bits(64);
    lf[LW-1:0] = LW'(len);
    predict(CMD_READ, addr, len, 32'h0);
    send_cmd(CMD_READ, addr, lf);
  endtask

  task automatic pulse_eoc(input logic [31:0] c);
    @(negedge clk);
    eoc_in = '{valid: 1'b1, code: c};
    @(negedge clk);
    eoc_in.valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() > 0) @(negedge clk);
    repeat (2 * CPB) @(negedge clk);
  endtask

  //////////////////////////////
  // Monitors
  //////////////////////////////

  // Decodes uart_tx_o, samples near each bit middle
  initial begin
    logic [7:0] b;
    int         i;
    @(posedge rst_n);
    forever begin
      @(negedge uart_tx);
      repeat (CPB / 2) @(negedge clk);
      assert (uart_tx == 1'b0) else begin
        errors++;
        $display("Start bit on the transmit line did not hold low at %0t", $time);
      end
      for (i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        b[i] = uart_tx;
      end
      if (PARITY_EN) begin
        repeat (CPB) @(negedge clk);
        assert (uart_tx == ^b) else begin
          errors++;
          $display("Transmitted byte %02h carries a wrong parity bit at %0t", b, $time);
        end
      end
      repeat (CPB) @(negedge clk);
      assert (uart_tx == 1'b1) else begin
        errors++;
        $display("Transmitted byte %02h has no stop bit at %0t", b, $time);
      end
      got_q.push_back(b);
    end
  end

  // Compares each sampled byte with the next expected one
  initial begin
    logic [7:0] got;
    logic [7:0] want;
    forever begin
      @(negedge clk);
      if (got_q.size() > 0) begin
        got = got_q.pop_front();
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("DUT sent byte %02h when no response was expected", got);
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          checked++;
          assert (got == want) else begin
            errors++;
            $display("Fail at %0t: response byte %02h, expected %02h", $time, got, want);
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && exec_out.valid) begin
      exec_cnt++;
      exec_entry = exec_out.entry;
    end
    if (rst_n && parity_err) begin
      perr_cnt++;
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("Run stalled after %0d cycles with %0d response bytes missing",
             cycles, exp_q.size());
    $display("%0d response bytes checked, %0d errors", checked, errors);
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    logic [63:0] addr;
    logic [63:0] addr0;
    logic [63:0] entry;
    logic [31:0] code;
    int          len;
    int          k;
    int          n0;
    uart_rx = 1'b1;
    rst_n   = 1'b0;
    eoc_in  = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // ACK challenge
    predict(ACK, 64'h0, 0, 32'h0);
    send_frame(ACK, 1'b0);
    wait_drain();

    // Write then read back a random range
    addr = rand_bits(64);
    len  = 1 + int'(rand_bits(6)) % 40;
    write_mem(addr, len);
    wait_drain();
    read_mem(addr, len);
    wait_drain();

    // Write across the top of memory, read the wrapped part from zero
    k    = 1 + int'(rand_bits(3));
    len  = k + 4 + int'(rand_bits(4));
    addr = rand_bits(64);
    addr[AW-1:0] = AW'(MEM_DEPTH - k);
    write_mem(addr, len);
    wait_drain();
    addr0 = rand_bits(64);
    addr0[AW-1:0] = '0;
    read_mem(addr0, len - k);
    wait_drain();

    // Exec with a random entry
    entry = rand_bits(64);
    n0    = exec_cnt;
    predict(CMD_EXEC, entry, 0, 32'h0);
    send_cmd(CMD_EXEC, entry, 64'h0);
    wait_drain();
    assert (exec_cnt == n0 + 1 && exec_entry == entry) else begin
      errors++;
      $display("Fail at %0t: %0d exec pulses with entry %h, expected one with %h",
               $time, exec_cnt - n0, exec_entry, entry);
    end

    // EOC in idle, then EOC raised during a read stream
    code = 32'(rand_bits(32));
    predict(EOC, 64'h0, 0, code);
    pulse_eoc(code);
    wait_drain();
    read_mem(addr, len);
    code = 32'(rand_bits(32));
    predict(EOC, 64'h0, 0, code);
    n0 = exp_q.size();
    while (exp_q.size() > n0 - 2) @(negedge clk);
    pulse_eoc(code);
    wait_drain();

    // Bad parity is flagged and not answered
    n0 = perr_cnt;
    send_frame(ACK, 1'b1);
    repeat (3 * FRAME_BITS * CPB) @(negedge clk);
    assert (perr_cnt == n0 + 1) else begin
      errors++;
      $display("Fail at %0t: %0d parity error pulses, expected 1", $time, perr_cnt - n0);
    end
    predict(ACK, 64'h0, 0, 32'h0);
    send_frame(ACK, 1'b0);
    wait_drain();

    repeat (2 * FRAME_BITS * CPB) @(negedge clk);
    assert (exec_cnt == 1 && perr_cnt == 1) else begin
      errors++;
      $display("Fail at %0t: %0d exec pulses and %0d parity pulses in total, expected 1 each",
               $time, exec_cnt, perr_cnt);
    end
    $display("%0d response bytes checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/uart_line_pkg.sv
verilog/uart_dbg_pkg.sv
verilog/uart_byte_rx.sv
verilog/uart_byte_tx.sv
verilog/uart_dbg_engine.sv
verilog/uart_dbg_top.sv
bench/tb_uart_dbg.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the UART debug endpoint testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module tb_uart_dbg -Mdir obj_dir -o tb_uart_dbg

./obj_dir/tb_uart_dbg | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
